// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_dcache
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS ?= --binary --timing --assert
FAIL_MSG = *** TEST FAILED ***
PASS_MSG = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/dcache_checker.sv
`timescale 1ns/100ps

// watches the DUT ports and keeps a shadow of the memory as the core sees it
module dcache_checker
    import dcache_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  logic                   req_ready,
    input  req_kind_t              req_kind,
    input  access_size_t           req_size,
    input  logic                   req_unsigned,
    input  logic [CORE_ADDR_W-1:0] req_addr,
    input  logic [WORD_W-1:0]      req_wdata,
    input  logic                   rsp_valid,
    input  logic [WORD_W-1:0]      rsp_data,
    input  logic                   mem_rd_valid,
    input  logic                   mem_rd_ready,
    input  logic [MEM_ADDR_W-1:0]  mem_rd_addr,
    input  logic                   mem_wr_valid,
    input  logic                   mem_wr_ready,
    input  logic [MEM_ADDR_W-1:0]  mem_wr_addr,
    input  logic [BEAT_W-1:0]      mem_wr_data,
    input  logic [1:0]             exp_class,
    input  logic                   row_done,
    output int                     data_errors,
    output int                     timing_errors,
    output int                     traffic_errors
);

    localparam logic [1:0] CLS_HIT = 2'd0;
    localparam logic [1:0] CLS_EVICT = 2'd2;
    // with 8 sets the set index is addr[8:6] and the tag addr[15:9]
    localparam int SET_W = 3;
    localparam int TAG_W = CORE_ADDR_W - LINE_OFFSET_W - SET_W;

    logic [7:0]             shadow [65536];
    logic [TAG_W-1:0]       resident [1 << SET_W];
    logic [TAG_W-1:0]       old_tag;
    logic [WORD_W-1:0]      exp_q [$];
    logic [CORE_ADDR_W-1:0] cur_addr;
    logic [1:0]             cur_class;
    int                     cyc;
    int                     xfer_cyc;
    int                     rd_beats;
    int                     wr_beats;
    integer                 seed;

    // same fill sequence as the memory model
    initial begin
        seed = 70;
        for (int i = 0; i < 65536; i++) begin
            shadow[i] = 8'($random(seed));
        end
        for (int s = 0; s < (1 << SET_W); s++) begin
            resident[s] = '0;
        end
        old_tag = '0;
        data_errors = 0;
        timing_errors = 0;
        traffic_errors = 0;
        cyc = 0;
        xfer_cyc = 0;
        rd_beats = 0;
        wr_beats = 0;
        cur_addr = '0;
        cur_class = CLS_HIT;
    end

    function automatic logic [WORD_W-1:0] load_value(
        input logic [CORE_ADDR_W-1:0] addr,
        input access_size_t size,
        input logic uns
    );
        logic [7:0]  b0;
        logic [15:0] h0;
        b0 = shadow[addr];
        h0 = {shadow[16'(addr + 1)], shadow[addr]};
        if (size == SIZE_BYTE) begin
            return uns ? {24'h0, b0} : {{24{b0[7]}}, b0};
        end else if (size == SIZE_HALF) begin
            return uns ? {16'h0, h0} : {{16{h0[15]}}, h0};
        end
        return {shadow[16'(addr + 3)], shadow[16'(addr + 2)], h0};
    endfunction

    function automatic logic [BEAT_W-1:0] shadow_beat(input logic [MEM_ADDR_W-1:0] baddr);
        logic [BEAT_W-1:0] beat;
        for (int b = 0; b < BEAT_BYTES; b++) begin
            beat[b*8 +: 8] = shadow[{baddr, 4'(b)}];
        end
        return beat;
    endfunction

    always @(posedge clk) begin
        logic [WORD_W-1:0]     exp;
        logic [MEM_ADDR_W-1:0] exp_rd;
        logic [MEM_ADDR_W-1:0] exp_wr;
        int                    exp_rd_cnt;
        int                    exp_wr_cnt;
        int                    nbytes;
        if (!rst) begin
            cyc++;
            if (rsp_valid) begin
                if (exp_q.size() == 0) begin
                    $display("response seen while no load was waiting for one");
                    timing_errors++;
                end else begin
                    exp = exp_q.pop_front();
                    if (rsp_data !== exp) begin
                        $display("[ERROR] rsp_data got %h expected %h", rsp_data, exp);
                        data_errors++;
                    end
                    if ((cur_class == CLS_HIT) && (cyc != xfer_cyc + 1)) begin
                        $display("load hit answered %0d cycles after transfer", cyc - xfer_cyc);
                        timing_errors++;
                    end
                end
            end
            if (mem_rd_valid && mem_rd_ready) begin
                exp_rd = MEM_ADDR_W'(((cur_addr >> 4) & 16'hfffc) + 16'(rd_beats));
                if (mem_rd_addr !== exp_rd) begin
                    $display("[ERROR] mem_rd_addr got %h expected %h", mem_rd_addr, exp_rd);
                    traffic_errors++;
                end
                rd_beats++;
            end
            if (mem_wr_valid && mem_wr_ready) begin
                // the victim is the line that the previous access to this set brought in
                exp_wr = {old_tag, cur_addr[LINE_OFFSET_W +: SET_W], 2'(wr_beats)};
                if (mem_wr_addr !== exp_wr) begin
                    $display("[ERROR] mem_wr_addr got %h expected %h", mem_wr_addr, exp_wr);
                    traffic_errors++;
                end
                if (mem_wr_data !== shadow_beat(exp_wr)) begin
                    $display("[ERROR] mem_wr_data got %h expected %h",
                             mem_wr_data, shadow_beat(exp_wr));
                    data_errors++;
                end
                wr_beats++;
            end
            if (row_done) begin
                exp_rd_cnt = (cur_class == CLS_HIT) ? 0 : 4;
                exp_wr_cnt = (cur_class == CLS_EVICT) ? 4 : 0;
                if (rd_beats != exp_rd_cnt) begin
                    $display("[ERROR] mem_rd beat count got %h expected %h",
                             rd_beats, exp_rd_cnt);
                    traffic_errors++;
                end
                if (wr_beats != exp_wr_cnt) begin
                    $display("[ERROR] mem_wr beat count got %h expected %h",
                             wr_beats, exp_wr_cnt);
                    traffic_errors++;
                end
            end
            if (req_valid && req_ready) begin
                cur_addr = req_addr;
                cur_class = exp_class;
                xfer_cyc = cyc;
                rd_beats = 0;
                wr_beats = 0;
                old_tag = resident[req_addr[LINE_OFFSET_W +: SET_W]];
                resident[req_addr[LINE_OFFSET_W +: SET_W]] = req_addr[CORE_ADDR_W-1 -: TAG_W];
                if (req_kind == REQ_LOAD) begin
                    exp_q.push_back(load_value(req_addr, req_size, req_unsigned));
                end else begin
                    nbytes = (req_size == SIZE_BYTE) ? 1 : (req_size == SIZE_HALF) ? 2 : 4;
                    for (int i = 0; i < nbytes; i++) begin
                        shadow[16'(req_addr + i)] = req_wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: bench/tb_dcache.sv
`timescale 1ns/100ps

module tb_dcache
    import dcache_pkg::*;
;

    localparam int ROWS = 16;
    localparam int CLK_PERIOD = 4;
    localparam logic [1:0] CLS_HIT = 2'd0;
    localparam logic [1:0] CLS_FILL = 2'd1;
    localparam logic [1:0] CLS_EVICT = 2'd2;

    logic                   clk;
    logic                   rst;
    logic                   req_valid;
    logic                   req_ready;
    req_kind_t              req_kind;
    access_size_t           req_size;
    logic                   req_unsigned;
    logic [CORE_ADDR_W-1:0] req_addr;
    logic [WORD_W-1:0]      req_wdata;
    logic                   rsp_valid;
    logic [WORD_W-1:0]      rsp_data;
    logic                   mem_rd_valid;
    logic                   mem_rd_ready;
    logic [MEM_ADDR_W-1:0]  mem_rd_addr;
    logic                   mem_rsp_valid;
    logic [BEAT_W-1:0]      mem_rsp_data;
    logic                   mem_wr_valid;
    logic                   mem_wr_ready;
    logic [MEM_ADDR_W-1:0]  mem_wr_addr;
    logic [BEAT_W-1:0]      mem_wr_data;
    logic [1:0]             exp_class;
    logic                   row_done;
    int                     data_errors;
    int                     timing_errors;
    int                     traffic_errors;

    // stimulus table columns
    req_kind_t              kind_tab  [ROWS];
    access_size_t           size_tab  [ROWS];
    logic                   uns_tab   [ROWS];
    logic [CORE_ADDR_W-1:0] addr_tab  [ROWS];
    logic [WORD_W-1:0]      wdata_tab [ROWS];
    logic [1:0]             class_tab [ROWS];

    // memory model state
    logic [7:0]        mem [65536];
    logic              rd_pipe_valid;
    logic [BEAT_W-1:0] rd_pipe_data;
    integer            seed;

    dcache_top #(.SETS(8)) dut0 (.*);

    dcache_checker chk0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic set_row(input int i, input req_kind_t k, input access_size_t s,
                           input logic u, input logic [15:0] a, input logic [31:0] d,
                           input logic [1:0] c);
        kind_tab[i] = k;
        size_tab[i] = s;
        uns_tab[i] = u;
        addr_tab[i] = a;
        wdata_tab[i] = d;
        class_tab[i] = c;
    endtask

    initial begin
        set_row(0, REQ_LOAD, SIZE_WORD, 1'b0, 16'h1040, 32'h0, CLS_FILL);
        set_row(1, REQ_LOAD, SIZE_WORD, 1'b0, 16'h1044, 32'h0, CLS_HIT);
        set_row(2, REQ_LOAD, SIZE_BYTE, 1'b0, 16'h1047, 32'h0, CLS_HIT);
        set_row(3, REQ_LOAD, SIZE_BYTE, 1'b1, 16'h1047, 32'h0, CLS_HIT);
        set_row(4, REQ_LOAD, SIZE_HALF, 1'b0, 16'h104a, 32'h0, CLS_HIT);
        set_row(5, REQ_LOAD, SIZE_HALF, 1'b1, 16'h105e, 32'h0, CLS_HIT);
        set_row(6, REQ_STORE, SIZE_WORD, 1'b0, 16'h1050, 32'hdeadbeef, CLS_HIT);
        set_row(7, REQ_STORE, SIZE_BYTE, 1'b0, 16'h1055, 32'h000000a5, CLS_HIT);
        set_row(8, REQ_LOAD, SIZE_WORD, 1'b0, 16'h1054, 32'h0, CLS_HIT);
        // the stored byte has its top bit set
        set_row(9, REQ_LOAD, SIZE_BYTE, 1'b0, 16'h1055, 32'h0, CLS_HIT);
        // set 1 is dirty now so the conflicting load writes it back first
        set_row(10, REQ_LOAD, SIZE_WORD, 1'b0, 16'h3040, 32'h0, CLS_EVICT);
        set_row(11, REQ_LOAD, SIZE_WORD, 1'b0, 16'h1050, 32'h0, CLS_FILL);
        set_row(12, REQ_STORE, SIZE_HALF, 1'b0, 16'h0282, 32'h00008001, CLS_FILL);
        set_row(13, REQ_LOAD, SIZE_HALF, 1'b0, 16'h0282, 32'h0, CLS_HIT);
        set_row(14, REQ_LOAD, SIZE_WORD, 1'b0, 16'h2280, 32'h0, CLS_EVICT);
        set_row(15, REQ_LOAD, SIZE_WORD, 1'b0, 16'h0280, 32'h0, CLS_FILL);
    end

    // memory model returns read data two cycles after the beat is taken
    always @(posedge clk) begin
        logic [BEAT_W-1:0] beat;
        mem_rd_ready <= ($random(seed) % 4) != 0;
        mem_wr_ready <= ($random(seed) % 4) != 0;
        mem_rsp_valid <= rd_pipe_valid;
        mem_rsp_data <= rd_pipe_data;
        rd_pipe_valid <= mem_rd_valid && mem_rd_ready;
        for (int b = 0; b < BEAT_BYTES; b++) begin
            beat[b*8 +: 8] = mem[{mem_rd_addr, 4'(b)}];
            if (mem_wr_valid && mem_wr_ready) begin
                mem[{mem_wr_addr, 4'(b)}] <= mem_wr_data[b*8 +: 8];
            end
        end
        rd_pipe_data <= beat;
    end

    initial begin
        #(ROWS * 200 * CLK_PERIOD);
        $display("watchdog expired before the stimulus table finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_kind = REQ_LOAD;
        req_size = SIZE_WORD;
        req_unsigned = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        mem_rd_ready = 1'b0;
        mem_wr_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data = '0;
        rd_pipe_valid = 1'b0;
        rd_pipe_data = '0;
        exp_class = CLS_HIT;
        row_done = 1'b0;
        seed = 70;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'($random(seed));
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            @(posedge clk);
            row_done <= 1'b0;
            req_valid <= 1'b1;
            req_kind <= kind_tab[r];
            req_size <= size_tab[r];
            req_unsigned <= uns_tab[r];
            req_addr <= addr_tab[r];
            req_wdata <= wdata_tab[r];
            exp_class <= class_tab[r];
            do @(posedge clk); while (!req_ready);
            req_valid <= 1'b0;
            // a load ends with its response, a store with req_ready back high
            if (kind_tab[r] == REQ_LOAD) begin
                do @(posedge clk); while (!rsp_valid);
            end else begin
                do @(posedge clk); while (!req_ready);
            end
            row_done <= 1'b1;
        end
        @(posedge clk);
        row_done <= 1'b0;
        repeat (4) @(posedge clk);
        $display("errors: data %0d, timing %0d, traffic %0d",
                 data_errors, timing_errors, traffic_errors);
        if (data_errors + timing_errors + traffic_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: design/cache_ctrl.sv
`timescale 1ns/100ps

module cache_ctrl
    import dcache_pkg::*;
#(
    parameter int SETS = 8,
    localparam int IDX_W = $clog2(SETS),
    localparam int SET_W = (SETS > 1) ? IDX_W : 1,
    localparam int TAG_W = CORE_ADDR_W - LINE_OFFSET_W - IDX_W
) (
    input  logic                     clk,
    input  logic                     rst,
    // core request and response
    input  logic                     req_valid,
    output logic                     req_ready,
    input  req_kind_t                req_kind,
    input  access_size_t             req_size,
    input  logic                     req_unsigned,
    input  logic [CORE_ADDR_W-1:0]   req_addr,
    input  logic [WORD_W-1:0]        req_wdata,
    output logic                     rsp_valid,
    // memory read
    output logic                     mem_rd_valid,
    input  logic                     mem_rd_ready,
    output logic [MEM_ADDR_W-1:0]    mem_rd_addr,
    input  logic                     mem_rsp_valid,
    input  logic [BEAT_W-1:0]        mem_rsp_data,
    // memory write
    output logic                     mem_wr_valid,
    input  logic                     mem_wr_ready,
    output logic [MEM_ADDR_W-1:0]    mem_wr_addr,
    output logic [BEAT_W-1:0]        mem_wr_data,
    // tag store
    output logic [SET_W-1:0]         lookup_set,
    output logic [TAG_W-1:0]         lookup_tag,
    input  logic                     hit,
    input  logic                     victim_dirty,
    input  logic [TAG_W-1:0]         victim_tag,
    output logic                     fill_en,
    output logic                     dirty_en,
    output logic [SET_W-1:0]         update_set,
    output logic [TAG_W-1:0]         fill_tag,
    // data store
    line_write_if.ctrl               wr,
    output logic [SET_W-1:0]         rd_set,
    output logic [LINE_OFFSET_W-3:0] rd_word,
    output logic [BEAT_CNT_W-1:0]    ev_beat,
    input  logic [BEAT_W-1:0]        ev_data,
    // load alignment
    output access_size_t             align_size,
    output logic                     align_unsigned,
    output logic [1:0]               align_offset
);

    localparam logic [BEAT_CNT_W-1:0] LAST_BEAT = BEAT_CNT_W'(BEATS_PER_LINE - 1);

    dcache_state_t state;
    dcache_state_t next_state;

    // registered request, it doubles as the pending request during a miss
    logic                   cr_valid;
    req_kind_t              cr_kind;
    access_size_t           cr_size;
    logic                   cr_unsigned;
    logic [CORE_ADDR_W-1:0] cr_addr;
    logic [WORD_W-1:0]      cr_wdata;

    logic [SET_W-1:0]         cr_set;
    logic [LINE_OFFSET_W-1:0] cr_byte;
    logic                     lookup_miss;
    logic                     store_hit;
    logic                     refill_last;
    logic [BEAT_CNT_W-1:0]    rd_cnt;
    logic                     rd_all;
    logic [BEAT_CNT_W-1:0]    rsp_cnt;
    logic [BEAT_CNT_W-1:0]    ev_cnt;
    logic [CORE_ADDR_W-1:0]   victim_base;
    logic [3:0]               size_mask;
    logic [BEAT_BYTES-1:0]    store_mask;
    logic [BEAT_W-1:0]        store_data;

    assign cr_set = SET_W'(line_set(cr_addr, SETS));
    assign cr_byte = line_byte(cr_addr);
    assign lookup_set = cr_set;
    assign lookup_tag = TAG_W'(line_tag(cr_addr, SETS));

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            cr_kind <= req_kind;
            cr_size <= req_size;
            cr_unsigned <= req_unsigned;
            cr_addr <= req_addr;
            cr_wdata <= req_wdata;
        end
    end

    // after the last refill beat the held request is looked up again and now hits
    always_ff @(posedge clk) begin
        if (rst) begin
            cr_valid <= 1'b0;
        end else begin
            cr_valid <= (req_valid && req_ready) || refill_last;
        end
    end

    assign lookup_miss = (state == ST_READY) && cr_valid && !hit;
    assign store_hit = (state == ST_READY) && cr_valid && hit && (cr_kind == REQ_STORE);
    assign rsp_valid = (state == ST_READY) && cr_valid && hit && (cr_kind == REQ_LOAD);
    assign req_ready = (state == ST_READY) && !lookup_miss;
    assign refill_last = (state == ST_MISS) && mem_rsp_valid && (rsp_cnt == LAST_BEAT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_RESET: next_state = ST_READY;
            ST_READY: begin
                if (lookup_miss) begin
                    next_state = victim_dirty ? ST_EVICT : ST_MISS;
                end
            end
            ST_EVICT: begin
                if (mem_wr_ready && (ev_cnt == LAST_BEAT)) begin
                    next_state = ST_MISS;
                end
            end
            ST_MISS: begin
                if (refill_last) begin
                    next_state = ST_READY;
                end
            end
            default: next_state = ST_RESET;
        endcase
    end

    // beat counters wrap back to zero after a full line
    always_ff @(posedge clk) begin
        if (rst) begin
            ev_cnt <= '0;
            rd_cnt <= '0;
            rd_all <= 1'b0;
            rsp_cnt <= '0;
        end else begin
            if (mem_wr_valid && mem_wr_ready) begin
                ev_cnt <= ev_cnt + 1'b1;
            end
            if (mem_rd_valid && mem_rd_ready) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_cnt == LAST_BEAT) begin
                    rd_all <= 1'b1;
                end
            end
            if ((state == ST_MISS) && mem_rsp_valid) begin
                rsp_cnt <= rsp_cnt + 1'b1;
            end
            if (refill_last) begin
                rd_all <= 1'b0;
            end
        end
    end

    assign mem_rd_valid = (state == ST_MISS) && !rd_all;
    assign mem_rd_addr = {cr_addr[CORE_ADDR_W-1:LINE_OFFSET_W], rd_cnt};

    // victim line address rebuilt from its stored tag and the shared set index
    assign victim_base = (CORE_ADDR_W'(victim_tag) << (LINE_OFFSET_W + IDX_W))
                       | (CORE_ADDR_W'(cr_set) << LINE_OFFSET_W);
    assign mem_wr_valid = (state == ST_EVICT);
    assign mem_wr_addr = {victim_base[CORE_ADDR_W-1:LINE_OFFSET_W], ev_cnt};
    assign mem_wr_data = ev_data;
    assign ev_beat = ev_cnt;

    always_comb begin
        case (cr_size)
            SIZE_BYTE: size_mask = 4'b0001;
            SIZE_HALF: size_mask = 4'b0011;
            default:   size_mask = 4'b1111;
        endcase
    end

    // store lands at its byte offset inside the beat
    assign store_mask = BEAT_BYTES'(size_mask) << cr_byte[3:0];
    assign store_data = BEAT_W'(cr_wdata) << {cr_byte[3:0], 3'b000};

    // refill beats and store merges share the write port, never in the same state
    always_comb begin
        wr.wr_en = store_hit;
        wr.set = cr_set;
        wr.beat = cr_byte[LINE_OFFSET_W-1:4];
        wr.byte_mask = store_mask;
        wr.beat_data = store_data;
        if ((state == ST_MISS) && mem_rsp_valid) begin
            wr.wr_en = 1'b1;
            wr.beat = rsp_cnt;
            wr.byte_mask = '1;
            wr.beat_data = mem_rsp_data;
        end
    end

    assign fill_en = refill_last;
    assign dirty_en = store_hit;
    assign update_set = cr_set;
    assign fill_tag = lookup_tag;

    assign rd_set = cr_set;
    assign rd_word = line_word(cr_addr);
    assign align_size = cr_size;
    assign align_unsigned = cr_unsigned;
    assign align_offset = cr_addr[1:0];

    a_rd_in_miss: assert property (
        @(posedge clk) disable iff (rst)
        mem_rd_valid |-> (state inside {ST_MISS, ST_EVICT})
    );

    // a stalled read beat keeps its address until memory takes it
    a_rd_addr_hold: assert property (
        @(posedge clk) disable iff (rst)
        (mem_rd_valid && !mem_rd_ready) |=> (mem_rd_valid && $stable(mem_rd_addr))
    );

    a_rsp_load: assert property (
        @(posedge clk) disable iff (rst)
        rsp_valid |-> (cr_kind == REQ_LOAD)
    );

endmodule

// File: design/data_store.sv
`timescale 1ns/100ps

module data_store
    import dcache_pkg::*;
#(
    parameter int SETS = 8,
    localparam int SET_W = (SETS > 1) ? $clog2(SETS) : 1
) (
    input  logic                     clk,
    line_write_if.store              wr,
    input  logic [SET_W-1:0]         rd_set,
    input  logic [LINE_OFFSET_W-3:0] rd_word,
    input  logic [BEAT_CNT_W-1:0]    ev_beat,
    output logic [WORD_W-1:0]        rd_data,
    output logic [BEAT_W-1:0]        ev_data
);

    // each line kept as memory-bus beats
    logic [BEAT_W-1:0] lines [SETS][BEATS_PER_LINE];
    logic [BEAT_W-1:0] rd_beat;

    always_ff @(posedge clk) begin
        if (wr.wr_en) begin
            for (int b = 0; b < BEAT_BYTES; b++) begin
                if (wr.byte_mask[b]) begin
                    lines[wr.set][wr.beat][b*8 +: 8] <= wr.beat_data[b*8 +: 8];
                end
            end
        end
    end

    // upper word bits pick the beat, lower ones the word inside it
    assign rd_beat = lines[rd_set][rd_word[LINE_OFFSET_W-3:2]];
    assign rd_data = rd_beat[rd_word[1:0]*WORD_W +: WORD_W];

    // write-back reads the same set, one beat at a time
    assign ev_data = lines[rd_set][ev_beat];

endmodule

// File: design/dcache_pkg.sv
package dcache_pkg;

    // core side
    localparam int CORE_ADDR_W = 16;
    localparam int WORD_W = 32;

    // line geometry
    localparam int LINE_BYTES = 64;
    localparam int LINE_OFFSET_W = 6;

    // memory bus, one line is four beats
    localparam int BEAT_W = 128;
    localparam int BEAT_BYTES = 16;
    localparam int BEATS_PER_LINE = 4;
    localparam int BEAT_CNT_W = 2;
    localparam int MEM_ADDR_W = 12;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } access_size_t;

    typedef enum logic {
        REQ_LOAD,
        REQ_STORE
    } req_kind_t;

    typedef enum logic [1:0] {
        ST_RESET,
        ST_READY,   // lookup, hits complete here
        ST_MISS,    // refill from memory
        ST_EVICT    // write back the dirty victim first
    } dcache_state_t;

    // set index, wide enough for the largest cache, callers slice it
    function automatic logic [7:0] line_set(
        input logic [CORE_ADDR_W-1:0] addr,
        input int unsigned sets
    );
        return 8'((addr / LINE_BYTES) % sets);
    endfunction

    // tag sits above offset and index
    function automatic logic [CORE_ADDR_W-1:0] line_tag(
        input logic [CORE_ADDR_W-1:0] addr,
        input int unsigned sets
    );
        return addr >> (LINE_OFFSET_W + $clog2(sets));
    endfunction

    function automatic logic [LINE_OFFSET_W-3:0] line_word(
        input logic [CORE_ADDR_W-1:0] addr
    );
        return addr[LINE_OFFSET_W-1:2];
    endfunction

    function automatic logic [LINE_OFFSET_W-1:0] line_byte(
        input logic [CORE_ADDR_W-1:0] addr
    );
        return addr[LINE_OFFSET_W-1:0];
    endfunction

endpackage

// File: design/dcache_top.sv
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int SETS = 8,
    localparam int IDX_W = $clog2(SETS),
    localparam int SET_W = (SETS > 1) ? IDX_W : 1,
    localparam int TAG_W = CORE_ADDR_W - LINE_OFFSET_W - IDX_W
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    output logic                   req_ready,
    input  req_kind_t              req_kind,
    input  access_size_t           req_size,
    input  logic                   req_unsigned,
    input  logic [CORE_ADDR_W-1:0] req_addr,
    input  logic [WORD_W-1:0]      req_wdata,
    output logic                   rsp_valid,
    output logic [WORD_W-1:0]      rsp_data,
    output logic                   mem_rd_valid,
    input  logic                   mem_rd_ready,
    output logic [MEM_ADDR_W-1:0]  mem_rd_addr,
    input  logic                   mem_rsp_valid,
    input  logic [BEAT_W-1:0]      mem_rsp_data,
    output logic                   mem_wr_valid,
    input  logic                   mem_wr_ready,
    output logic [MEM_ADDR_W-1:0]  mem_wr_addr,
    output logic [BEAT_W-1:0]      mem_wr_data
);

    // tag path
    logic [SET_W-1:0] lookup_set;
    logic [TAG_W-1:0] lookup_tag;
    logic             hit;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    logic             fill_en;
    logic             dirty_en;
    logic [SET_W-1:0] update_set;
    logic [TAG_W-1:0] fill_tag;

    // data path
    logic [SET_W-1:0]         rd_set;
    logic [LINE_OFFSET_W-3:0] rd_word;
    logic [BEAT_CNT_W-1:0]    ev_beat;
    logic [WORD_W-1:0]        rd_data;
    logic [BEAT_W-1:0]        ev_data;
    access_size_t             align_size;
    logic                     align_unsigned;
    logic [1:0]               align_offset;

    line_write_if #(.SETS(SETS)) line_wr ();

    cache_ctrl #(.SETS(SETS)) u_ctrl (.*, .wr(line_wr));

    tag_store #(.SETS(SETS)) u_tags (.*);

    data_store #(.SETS(SETS)) u_data (.*, .wr(line_wr));

    load_align u_align (
        .clk        (clk),
        .valid      (rsp_valid),
        .word_in    (rd_data),
        .size       (align_size),
        .is_unsigned(align_unsigned),
        .offset     (align_offset),
        .data_out   (rsp_data)
    );

endmodule

// File: design/line_write_if.sv
`timescale 1ns/100ps

// one byte-masked beat write into the line array per cycle
interface line_write_if
    import dcache_pkg::*;
#(
    parameter int SETS = 8
);
    localparam int SET_W = (SETS > 1) ? $clog2(SETS) : 1;

    logic                  wr_en;
    logic [SET_W-1:0]      set;
    logic [BEAT_CNT_W-1:0] beat;
    logic [BEAT_BYTES-1:0] byte_mask;
    logic [BEAT_W-1:0]     beat_data;

    modport ctrl (output wr_en, set, beat, byte_mask, beat_data);
    modport store (input wr_en, set, beat, byte_mask, beat_data);

endinterface

// File: design/load_align.sv
`timescale 1ns/100ps

module load_align
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              valid,
    input  logic [WORD_W-1:0] word_in,
    input  access_size_t      size,
    input  logic              is_unsigned,
    input  logic [1:0]        offset,
    output logic [WORD_W-1:0] data_out
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign sel_byte = word_in[offset*8 +: 8];
    // halves come from the upper or lower 16 bits only
    assign sel_half = word_in[offset[1]*16 +: 16];

    always_comb begin
        case (size)
            SIZE_BYTE: data_out = {{24{sel_byte[7] & ~is_unsigned}}, sel_byte};
            SIZE_HALF: data_out = {{16{sel_half[15] & ~is_unsigned}}, sel_half};
            default:   data_out = word_in;
        endcase
    end

    // the core never issues unaligned loads
    a_aligned: assert property (
        @(posedge clk)
        valid |-> !(((size == SIZE_HALF) && offset[0])
                 || ((size == SIZE_WORD) && (offset != 2'd0)))
    );

endmodule

// File: design/tag_store.sv
`timescale 1ns/100ps

module tag_store
    import dcache_pkg::*;
#(
    parameter int SETS = 8,
    localparam int SET_W = (SETS > 1) ? $clog2(SETS) : 1,
    localparam int TAG_W = CORE_ADDR_W - LINE_OFFSET_W - $clog2(SETS)
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [SET_W-1:0] lookup_set,
    input  logic [TAG_W-1:0] lookup_tag,
    input  logic             fill_en,
    input  logic             dirty_en,
    input  logic [SET_W-1:0] update_set,
    input  logic [TAG_W-1:0] fill_tag,
    output logic             hit,
    output logic             victim_dirty,
    output logic [TAG_W-1:0] victim_tag
);

    logic             valid [SETS];
    logic             dirty [SETS];
    logic [TAG_W-1:0] tags  [SETS];

    assign hit = valid[lookup_set] && (tags[lookup_set] == lookup_tag);

    // victim is whatever currently occupies the looked-up set
    assign victim_dirty = valid[lookup_set] && dirty[lookup_set];
    assign victim_tag = tags[lookup_set];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                valid[s] <= 1'b0;
                dirty[s] <= 1'b0;
                tags[s] <= '0;
            end
        end else if (fill_en) begin
            // refill completes clean
            valid[update_set] <= 1'b1;
            dirty[update_set] <= 1'b0;
            tags[update_set] <= fill_tag;
        end else if (dirty_en) begin
            dirty[update_set] <= 1'b1;
        end
    end

    // a refill and a store merge are separate FSM steps
    a_single_update: assert property (
        @(posedge clk) disable iff (rst)
        !(fill_en && dirty_en)
    );

    // index must be a plain slice of the address
    a_sets_pow2: assert property (
        @(posedge clk) (SETS & (SETS - 1)) == 0
    );

endmodule

// File: sources.f
design/dcache_pkg.sv
design/line_write_if.sv
design/tag_store.sv
design/data_store.sv
design/cache_ctrl.sv
design/load_align.sv
design/dcache_top.sv
bench/dcache_checker.sv
bench/tb_dcache.sv
